/* build.f */
+incdir+include
source/vbw_pkg.sv
source/vbw_osize_decode.sv
source/vbw_logic_lanes.sv
source/vbw_result_stage.sv
source/vbw_unit.sv
test/vbw_clk_gen.sv
test/vbw_unit_props.sv
test/vbw_unit_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the bitwise unit testbench with Verilator and runs it
# Exits nonzero when the build, the run or any check fails

set -u

cd "$(dirname "$0")" || exit 1

LOG_FILE=sim.log
SIM_BIN=vbw_sim

verilator --binary --timing --assert -Wno-fatal \
    --top-module vbw_unit_tb -f build.f -o "$SIM_BIN"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/"$SIM_BIN" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "SOME TESTS FAILED" "$LOG_FILE"; then
    exit 1
fi
exit 0

/* test/vbw_unit_tb.sv */
// Table-driven testbench for the vector bitwise unit
// Drives each row on the falling edge, predicts the result from the op rules
// and checks it when result_valid comes back

`timescale 1ns/1ps

`include "vbw_config.svh"

module vbw_unit_tb;

    import vbw_pkg::*;

    localparam int NUM_BYTES = `VBW_NUM_BYTES;
    localparam int TIMEOUT_CYCLES = 20;

    // One stimulus row where random flags replace the data fields
    typedef struct packed {
        vbw_op_e    op;
        vbw_sew_e   sew;
        logic       rand_a;
        logic       rand_b;
        vbw_src_t   srca;
        vbw_src_t   srcb;
        logic [7:0] reps;
    } stim_t;

    // Predicted result and the bytes that count
    typedef struct packed {
        vbw_byte_vec_t data;
        vbw_valid_t    cmp_mask;
    } expect_t;

    logic          clk;
    logic          arst_n;
    logic          op_valid;
    vbw_op_e       op;
    vbw_sew_e      sew;
    vbw_src_t      srca;
    vbw_src_t      srcb;
    vbw_byte_vec_t result;
    logic          result_valid;

    integer  seed;
    int      tests_run;
    int      tests_failed;
    int      test_errors;
    stim_t   table_q[$];
    // Results still in flight with the oldest first
    expect_t expect_q[$];

    vbw_clk_gen i_vbw_clk_gen (
        .clk    (clk),
        .arst_n (arst_n)
    );

    vbw_unit i_vbw_unit (
        .clk          (clk),
        .arst_n       (arst_n),
        .op_valid     (op_valid),
        .op           (op),
        .sew          (sew),
        .srca         (srca),
        .srcb         (srcb),
        .result       (result),
        .result_valid (result_valid)
    );

    bind vbw_unit vbw_unit_props i_vbw_unit_props (
        .clk          (clk),
        .arst_n       (arst_n),
        .op_valid     (op_valid),
        .result       (result),
        .result_valid (result_valid)
    );

    // Function index of an op as 0 for AND, 1 for OR and 2 for XOR
    function automatic int op_kind(input vbw_op_e op_i);
        case (op_i)
            OP_AND, OP_REDAND: return 0;
            OP_OR, OP_REDOR:   return 1;
            default:           return 2;
        endcase
    endfunction

    function automatic vbw_byte_t combine_bytes(input int kind, input vbw_byte_t x,
                                                input vbw_byte_t y);
        case (kind)
            0:       return x & y;
            1:       return x | y;
            default: return x ^ y;
        endcase
    endfunction

    // Behavioural model of the elementwise and reduction rules
    function automatic expect_t predict(input vbw_op_e op_i, input vbw_sew_e sew_i,
                                        input vbw_src_t a, input vbw_src_t b);
        expect_t       exp_v;
        vbw_byte_vec_t b_eff;
        vbw_byte_t     ident;
        vbw_byte_t     acc;
        int            kind;
        int            elem_bytes;
        logic          reduce;
        kind = op_kind(op_i);
        reduce = (op_i == OP_REDAND) || (op_i == OP_REDOR) || (op_i == OP_REDXOR);
        elem_bytes = 1 << int'(sew_i);
        ident = (kind == 0) ? '1 : '0;
        exp_v = '0;
        // Invalid srcb bytes act as the identity
        for (int i = 0; i < NUM_BYTES; i++) begin
            b_eff[i] = b.valid[i] ? b.data[i] : ident;
        end
        if (reduce) begin
            // Element 0 of srca folded with the same byte of every srcb element
            for (int j = 0; j < elem_bytes; j++) begin
                acc = a.data[j];
                for (int e = 0; e < NUM_BYTES / elem_bytes; e++) begin
                    acc = combine_bytes(kind, acc, b_eff[e * elem_bytes + j]);
                end
                exp_v.data[j] = acc;
                exp_v.cmp_mask[j] = 1'b1;
            end
        end else begin
            for (int i = 0; i < NUM_BYTES; i++) begin
                exp_v.data[i] = a.valid[i] ? combine_bytes(kind, a.data[i], b_eff[i]) : '0;
            end
            exp_v.cmp_mask = '1;
        end
        return exp_v;
    endfunction

    task automatic add_entry(input vbw_op_e op_i, input vbw_sew_e sew_i,
                             input logic rand_a, input vbw_byte_vec_t a_data,
                             input vbw_valid_t a_valid, input logic rand_b,
                             input vbw_byte_vec_t b_data, input vbw_valid_t b_valid,
                             input logic [7:0] reps);
        stim_t ent;
        ent.op = op_i;
        ent.sew = sew_i;
        ent.rand_a = rand_a;
        ent.rand_b = rand_b;
        ent.srca = '{data: a_data, valid: a_valid};
        ent.srcb = '{data: b_data, valid: b_valid};
        ent.reps = reps;
        table_q.push_back(ent);
    endtask

    task automatic build_table();
        vbw_op_e red_ops[3];
        red_ops = '{OP_REDAND, OP_REDOR, OP_REDXOR};
        // Elementwise ops with full valid then partly invalid srca
        add_entry(OP_AND, SEW8, 1'b1, '0, '1, 1'b1, '0, '1, 8'd1);
        add_entry(OP_OR, SEW8, 1'b1, '0, '1, 1'b1, '0, '1, 8'd1);
        add_entry(OP_XOR, SEW8, 1'b1, '0, '1, 1'b1, '0, '1, 8'd1);
        add_entry(OP_AND, SEW8, 1'b1, '0, 8'h5a, 1'b1, '0, '1, 8'd1);
        add_entry(OP_OR, SEW8, 1'b1, '0, 8'h81, 1'b1, '0, '1, 8'd1);
        add_entry(OP_XOR, SEW8, 1'b1, '0, 8'h3c, 1'b1, '0, '1, 8'd1);
        // Every reduction at every element width
        foreach (red_ops[k]) begin
            for (int s = 0; s < 4; s++) begin
                add_entry(red_ops[k], vbw_sew_e'(s), 1'b1, '0, '1, 1'b1, '0, '1, 8'd2);
            end
        end
        // Invalid srcb bytes hold values that would flip the fold
        add_entry(OP_REDAND, SEW8, 1'b0, 64'hffff_ffff_ffff_ffff, '1,
                  1'b0, 64'hff00_ffff_ffff_ffff, 8'hbf, 8'd1);
        add_entry(OP_REDOR, SEW8, 1'b0, 64'h0, '1, 1'b0, 64'h0000_00ff_0000_0000, 8'hef, 8'd1);
        add_entry(OP_REDXOR, SEW16, 1'b1, '0, '1, 1'b1, '0, 8'h3c, 8'd1);
        add_entry(OP_REDAND, SEW32, 1'b1, '0, '1, 1'b1, '0, 8'h0f, 8'd1);
        // Back to back runs
        add_entry(OP_XOR, SEW8, 1'b1, '0, '1, 1'b1, '0, '1, 8'd6);
        add_entry(OP_REDAND, SEW16, 1'b1, '0, '1, 1'b1, '0, 8'h7e, 8'd4);
        add_entry(OP_OR, SEW8, 1'b1, '0, 8'hc3, 1'b1, '0, '1, 8'd5);
    endtask

    // Pops the oldest prediction and compares the bytes that count
    task automatic collect_result();
        expect_t exp_v;
        if (expect_q.size() == 0) begin
            $display("Error at %0t ns: result_valid high with no operation pending", $time);
            test_errors++;
        end else begin
            exp_v = expect_q.pop_front();
            for (int i = 0; i < NUM_BYTES; i++) begin
                if (exp_v.cmp_mask[i] && result[i] !== exp_v.data[i]) begin
                    $display("mismatch at %0t ns: byte %0d is %h, expected %h",
                             $time, i, result[i], exp_v.data[i]);
                    test_errors++;
                end
            end
        end
    endtask

    // Outputs are stable at the falling edge so sample them before driving
    // An op issued on the last falling edge must have its result by now
    task automatic next_cycle();
        @(negedge clk);
        if (result_valid) begin
            collect_result();
        end else if (expect_q.size() != 0) begin
            $display("Error at %0t ns: result_valid late for an issued operation", $time);
            test_errors++;
        end
    endtask

    task automatic issue_op(input stim_t ent);
        vbw_src_t    a;
        vbw_src_t    b;
        logic [31:0] rnd;
        a = ent.srca;
        b = ent.srcb;
        for (int i = 0; i < NUM_BYTES; i++) begin
            if (ent.rand_a) begin
                rnd = $random(seed);
                a.data[i] = rnd[`VBW_BYTE_WIDTH-1:0];
            end
            if (ent.rand_b) begin
                rnd = $random(seed);
                b.data[i] = rnd[`VBW_BYTE_WIDTH-1:0];
            end
        end
        op_valid = 1'b1;
        op = ent.op;
        sew = ent.sew;
        srca = a;
        srcb = b;
        expect_q.push_back(predict(ent.op, ent.sew, a, b));
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (test_errors == 0) begin
            $display("test %0d %s ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s failed with %0d errors", tests_run, name, test_errors);
        end
        test_errors = 0;
    endtask

    task automatic run_entry(input stim_t ent);
        vbw_op_e  op_i;
        vbw_sew_e sew_i;
        int       wait_cycles;
        op_i = ent.op;
        sew_i = ent.sew;
        for (int r = 0; r < int'(ent.reps); r++) begin
            next_cycle();
            issue_op(ent);
        end
        next_cycle();
        op_valid = 1'b0;
        // Drain whatever is still in flight
        wait_cycles = 0;
        while (expect_q.size() != 0 && wait_cycles < TIMEOUT_CYCLES) begin
            next_cycle();
            wait_cycles++;
        end
        if (expect_q.size() != 0) begin
            $display("Error at %0t ns: timed out waiting for result_valid", $time);
            test_errors++;
            expect_q.delete();
        end
        finish_test($sformatf("%s %s x%0d", op_i.name(), sew_i.name(), ent.reps));
    endtask

    task automatic check_idle(input int cycles, input logic check_zero);
        for (int c = 0; c < cycles; c++) begin
            @(negedge clk);
            if (result_valid !== 1'b0) begin
                $display("Error at %0t ns: result_valid high with no operation issued", $time);
                test_errors++;
            end
            if (check_zero && result !== '0) begin
                $display("mismatch at %0t ns: result %h, expected zero", $time, result);
                test_errors++;
            end
        end
    endtask

    task automatic wait_reset_release();
        int wait_cycles;
        wait_cycles = 0;
        while (arst_n !== 1'b1 && wait_cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            wait_cycles++;
        end
        if (arst_n !== 1'b1) begin
            $display("Error at %0t ns: reset was never released", $time);
            test_errors++;
        end
    endtask

    initial begin
        $timeformat(-9, 0, "", 0);
        seed = 32'hb8e3;
        op_valid = 1'b0;
        op = OP_AND;
        sew = SEW8;
        srca = '0;
        srcb = '0;
        tests_run = 0;
        tests_failed = 0;
        test_errors = 0;
        build_table();
        wait_reset_release();
        check_idle(4, 1'b1);
        finish_test("idle after reset");
        foreach (table_q[i]) begin
            run_entry(table_q[i]);
        end
        // Nothing left over once traffic stops
        check_idle(3, 1'b0);
        finish_test("idle after traffic");
        $display("tests run %0d, passed %0d, failed %0d",
                 tests_run, tests_run - tests_failed, tests_failed);
        if (tests_failed == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* test/vbw_unit_props.sv */
// Concurrent checks on the output timing of the bitwise unit
// Bound into vbw_unit from the testbench

`timescale 1ns/1ps

module vbw_unit_props (
    input logic                   clk,
    input logic                   arst_n,
    input logic                   op_valid,
    input vbw_pkg::vbw_byte_vec_t result,
    input logic                   result_valid
);

    // No result while held in reset
    valid_low_in_reset: assert property (@(posedge clk) !arst_n |-> !result_valid)
        else $error("result_valid high during reset");

    // Every accepted op gives a valid pulse on the next edge
    valid_after_op: assert property (
        @(posedge clk) disable iff (!arst_n) op_valid |=> result_valid
    ) else $error("result_valid missing one cycle after op_valid");

    // And no pulse without an op
    no_valid_without_op: assert property (
        @(posedge clk) disable iff (!arst_n) !op_valid |=> !result_valid
    ) else $error("result_valid high without a preceding op_valid");

    // Register cleared by reset
    result_zero_after_reset: assert property (@(posedge clk) $rose(arst_n) |-> result == '0)
        else $error("result not zero one cycle after reset");

endmodule

/* test/vbw_clk_gen.sv */
// Clock and reset source for the bitwise unit testbench
// 10 ns clock, reset held low for the first cycles and released on a falling edge

`timescale 1ns/1ps

module vbw_clk_gen #(
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic arst_n
);

    // Free running clock
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Release away from the rising edge the flops sample on
    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
    end

endmodule

/* source/vbw_unit.sv */
// Top level of the vector bitwise unit
// Decoder, one lane block per logic function and the registered result stage

`timescale 1ns/1ps

module vbw_unit (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   op_valid,
    input  vbw_pkg::vbw_op_e       op,
    input  vbw_pkg::vbw_sew_e      sew,
    input  vbw_pkg::vbw_src_t      srca,
    input  vbw_pkg::vbw_src_t      srcb,
    output vbw_pkg::vbw_byte_vec_t result,
    output logic                   result_valid
);

    import vbw_pkg::*;

    // Decoded controls, shared by all blocks
    vbw_ctrl_t     ctrl;
    // Per-function lane outputs
    vbw_byte_vec_t and_lanes;
    vbw_byte_vec_t or_lanes;
    vbw_byte_vec_t xor_lanes;

    vbw_osize_decode i_vbw_osize_decode (
        .op   (op),
        .sew  (sew),
        .ctrl (ctrl)
    );

    vbw_logic_lanes #(.LOGIC_FUNC(FUNC_AND)) i_and_lanes (
        .ctrl  (ctrl),
        .srca  (srca),
        .srcb  (srcb),
        .lanes (and_lanes)
    );

    vbw_logic_lanes #(.LOGIC_FUNC(FUNC_OR)) i_or_lanes (
        .ctrl  (ctrl),
        .srca  (srca),
        .srcb  (srcb),
        .lanes (or_lanes)
    );

    vbw_logic_lanes #(.LOGIC_FUNC(FUNC_XOR)) i_xor_lanes (
        .ctrl  (ctrl),
        .srca  (srca),
        .srcb  (srcb),
        .lanes (xor_lanes)
    );

    // Only srca valids reach the output stage
    vbw_result_stage i_vbw_result_stage (
        .clk          (clk),
        .arst_n       (arst_n),
        .op_valid     (op_valid),
        .ctrl         (ctrl),
        .srca_valid   (srca.valid),
        .and_lanes    (and_lanes),
        .or_lanes     (or_lanes),
        .xor_lanes    (xor_lanes),
        .result       (result),
        .result_valid (result_valid)
    );

endmodule

/* source/vbw_result_stage.sv */
// Output stage of the bitwise unit
// Selects the active function's lanes and registers them with a valid pulse

`timescale 1ns/1ps

`include "vbw_config.svh"

module vbw_result_stage (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   op_valid,
    input  vbw_pkg::vbw_ctrl_t     ctrl,
    input  vbw_pkg::vbw_valid_t    srca_valid,
    input  vbw_pkg::vbw_byte_vec_t and_lanes,
    input  vbw_pkg::vbw_byte_vec_t or_lanes,
    input  vbw_pkg::vbw_byte_vec_t xor_lanes,
    output vbw_pkg::vbw_byte_vec_t result,
    output logic                   result_valid
);

    import vbw_pkg::*;

    localparam int NUM_BYTES = `VBW_NUM_BYTES;

    // Lanes of the selected function
    vbw_byte_vec_t sel_lanes;
    // Next value of the result register
    vbw_byte_vec_t result_d;

    // Function mux
    always_comb begin
        case (ctrl.func)
            FUNC_AND: sel_lanes = and_lanes;
            FUNC_OR:  sel_lanes = or_lanes;
            FUNC_XOR: sel_lanes = xor_lanes;
            default:  sel_lanes = '0;
        endcase
    end

    // Byte discard for elementwise ops
    // Reductions pass the tree output as is, upper bytes are don't care
    always_comb begin
        for (int i = 0; i < NUM_BYTES; i++) begin
            if (ctrl.is_reduct || srca_valid[i]) begin
                result_d[i] = sel_lanes[i];
            end else begin
                result_d[i] = '0;
            end
        end
    end

    // Valid pulse follows the accepted op by one cycle
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= op_valid;
        end
    end

    // Result holds its last value between ops
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            result <= '0;
        end else if (op_valid) begin
            result <= result_d;
        end
    end

endmodule

/* source/vbw_logic_lanes.sv */
// One logic function across all byte blocks, with the reduction tree
// Instanced once per function, the result stage picks the active one

`timescale 1ns/1ps

`include "vbw_config.svh"

module vbw_logic_lanes #(
    parameter vbw_pkg::vbw_func_e LOGIC_FUNC = vbw_pkg::FUNC_AND
) (
    input  vbw_pkg::vbw_ctrl_t     ctrl,
    input  vbw_pkg::vbw_src_t      srca,
    input  vbw_pkg::vbw_src_t      srcb,
    output vbw_pkg::vbw_byte_vec_t lanes
);

    import vbw_pkg::*;

    localparam int NUM_BLOCKS = `VBW_NUM_BYTES;
    localparam int NUM_STAGES = `VBW_NUM_STAGES;

    // All ones for AND, zero for OR and XOR
    localparam vbw_byte_t IDENTITY = {`VBW_BYTE_WIDTH{LOGIC_FUNC == FUNC_AND}};

    // This block owns the current op
    logic             lane_sel;
    // Srca after the function gate
    vbw_byte_vec_t    srca_gated;
    // Srcb with identity in invalid bytes
    vbw_byte_vec_t    srcb_bw;
    // One-hot fold distance, bit log2(E) set during a reduction
    logic [NUM_STAGES:0] stage_hit;

    // Per-byte operator of this instance
    function automatic vbw_byte_t logic_op(input vbw_byte_t a, input vbw_byte_t b);
        case (LOGIC_FUNC)
            FUNC_AND: return a & b;
            FUNC_OR:  return a | b;
            default:  return a ^ b;
        endcase
    endfunction

    assign lane_sel = (ctrl.func == LOGIC_FUNC);

    // Input gating and identity substitution
    always_comb begin
        for (int i = 0; i < NUM_BLOCKS; i++) begin
            // Idle function blocks see a zero srca
            srca_gated[i] = srca.data[i] & {`VBW_BYTE_WIDTH{lane_sel}};
            // Invalid srcb byte must not change the fold
            srcb_bw[i] = srcb.valid[i] ? srcb.data[i] : IDENTITY;
        end
    end

    // Pick the single stage that matches the element size
    // osize covers k >= log2(E), greater covers k <= log2(E)
    always_comb begin
        for (int k = 0; k < NUM_STAGES; k++) begin
            stage_hit[k] = ctrl.osize_vector[k] & ctrl.greater_osize_vector[k];
        end
        // Element spans the whole operand, no fold at all
        stage_hit[NUM_STAGES] = ctrl.is_reduct & ctrl.greater_osize_vector[NUM_STAGES];
    end

    // Reduction tree, evaluated from the top block down
    // Each block ORs its selected inputs and applies the function once
    always_comb begin : red_tree
        vbw_byte_vec_t blk_in;
        vbw_byte_vec_t blk_out;
        blk_in  = '0;
        blk_out = '0;
        for (int blk = NUM_BLOCKS - 1; blk >= 0; blk--) begin
            // Elementwise ops keep their own srca byte
            blk_in[blk] = srca_gated[blk] & {`VBW_BYTE_WIDTH{~ctrl.is_reduct}};
            for (int s = 0; s <= NUM_STAGES; s++) begin
                if (blk + (1 << s) < NUM_BLOCKS) begin
                    // Chain from the same byte of the next element up
                    blk_in[blk] |= blk_out[(blk + (1 << s)) % NUM_BLOCKS]
                                   & {`VBW_BYTE_WIDTH{stage_hit[s]}};
                end else begin
                    // Top element starts the chain with srca of element 0
                    // When E spans the operand this is the block's own byte
                    blk_in[blk] |= srca_gated[blk % (1 << s)]
                                   & {`VBW_BYTE_WIDTH{stage_hit[s]}};
                end
            end
            blk_out[blk] = logic_op(blk_in[blk], srcb_bw[blk]);
        end
        lanes = blk_out;
    end

endmodule

/* source/vbw_osize_decode.sv */
// Opcode and element width decoder for the bitwise unit
// Purely combinational, drives the lane blocks and the result stage

`timescale 1ns/1ps

`include "vbw_config.svh"

module vbw_osize_decode (
    input  vbw_pkg::vbw_op_e   op,
    input  vbw_pkg::vbw_sew_e  sew,
    output vbw_pkg::vbw_ctrl_t ctrl
);

    import vbw_pkg::*;

    localparam int NUM_STAGES = `VBW_NUM_STAGES;

    // Function select and reduction flag
    always_comb begin
        ctrl.func      = FUNC_AND;
        ctrl.is_reduct = 1'b0;
        case (op)
            OP_AND: begin
                ctrl.func = FUNC_AND;
            end
            OP_OR: begin
                ctrl.func = FUNC_OR;
            end
            OP_XOR: begin
                ctrl.func = FUNC_XOR;
            end
            OP_REDAND: begin
                ctrl.func      = FUNC_AND;
                ctrl.is_reduct = 1'b1;
            end
            OP_REDOR: begin
                ctrl.func      = FUNC_OR;
                ctrl.is_reduct = 1'b1;
            end
            OP_REDXOR: begin
                ctrl.func      = FUNC_XOR;
                ctrl.is_reduct = 1'b1;
            end
            default: begin
                ctrl.func      = FUNC_AND;
                ctrl.is_reduct = 1'b0;
            end
        endcase
    end

    // Width expansion for the reduction tree
    always_comb begin : size_expand
        int sew_log2;
        sew_log2 = int'(sew);
        // Stages at or above the element size fold, only for reductions
        for (int k = 0; k < NUM_STAGES; k++) begin
            ctrl.osize_vector[k] = ctrl.is_reduct && (k >= sew_log2);
        end
        // Element wider than 2^(k-1) bytes is the same as k <= log2(E)
        for (int k = 0; k <= NUM_STAGES; k++) begin
            ctrl.greater_osize_vector[k] = (k <= sew_log2);
        end
    end

endmodule

/* source/vbw_pkg.sv */
// Shared types for the vector bitwise unit
// Imported by every RTL block and by the testbench

`include "vbw_config.svh"

package vbw_pkg;

    // One byte lane
    typedef logic [`VBW_BYTE_WIDTH-1:0] vbw_byte_t;

    // Whole operand as an array of bytes
    typedef vbw_byte_t [`VBW_NUM_BYTES-1:0] vbw_byte_vec_t;

    // Per-byte valid mask
    typedef logic [`VBW_NUM_BYTES-1:0] vbw_valid_t;

    // Reduction stage enables
    // Bit k folds blocks 2^k apart
    typedef logic [`VBW_NUM_STAGES-1:0] vbw_osize_vec_t;

    // Element-size comparison vector, one bit wider than the stage enables
    // Bit k set when the element is wider than 2^(k-1) bytes
    typedef logic [`VBW_NUM_STAGES:0] vbw_greater_vec_t;

    // Source operand with its byte valids
    typedef struct packed {
        vbw_byte_vec_t data;
        vbw_valid_t    valid;
    } vbw_src_t;

    // Element width, encoded as log2 of the byte count
    typedef enum logic [1:0] {
        SEW8  = 2'd0,
        SEW16 = 2'd1,
        SEW32 = 2'd2,
        SEW64 = 2'd3
    } vbw_sew_e;

    // Supported operations
    typedef enum logic [2:0] {
        OP_AND    = 3'd0,
        OP_OR     = 3'd1,
        OP_XOR    = 3'd2,
        OP_REDAND = 3'd3,
        OP_REDOR  = 3'd4,
        OP_REDXOR = 3'd5
    } vbw_op_e;

    // Logic function of a lane block and of the result mux
    typedef enum logic [1:0] {
        FUNC_AND = 2'd0,
        FUNC_OR  = 2'd1,
        FUNC_XOR = 2'd2
    } vbw_func_e;

    // Decoder outputs shared by the lanes and the result stage
    typedef struct packed {
        logic             is_reduct;
        vbw_func_e        func;
        vbw_osize_vec_t   osize_vector;
        vbw_greater_vec_t greater_osize_vector;
    } vbw_ctrl_t;

endpackage

/* include/vbw_config.svh */
// Global sizing for the vector bitwise unit
// Include wherever the operand width or byte count is needed

`ifndef VBW_CONFIG_SVH
`define VBW_CONFIG_SVH

// Bytes per vector operand
// Power of two and at least 8 so a 64-bit element fits
`define VBW_NUM_BYTES 8

// Bits per byte lane
`define VBW_BYTE_WIDTH 8

// Derived operand width in bits
// Kept here so every user sees the same value
`define VBW_DATA_WIDTH (`VBW_NUM_BYTES * `VBW_BYTE_WIDTH)

// Number of reduction tree stages
// One stage per power-of-two fold distance below the full operand
`define VBW_NUM_STAGES $clog2(`VBW_NUM_BYTES)

`endif
